// ==== rfid_front_defines.svh ====
//--------------------
// Reset values, widths and fixed levels of the reader front end
// Counts are in ncs cycles and levels are raw A/D codes
// RFID_HF_CARRIER_DIV must stay between 1 and 4
//--------------------
`ifndef RFID_FRONT_DEFINES_SVH
`define RFID_FRONT_DEFINES_SVH

// Width of the parallel A/D sample bus
`define RFID_ADC_WIDTH 8

// Mode 111 with all options clear, so every pin starts low
`define RFID_CONF_RESET 8'he0
// Gives adc_clk a period of 192 ncs cycles
`define RFID_DIVISOR_RESET 8'd95

// Half period of the HF carrier
`define RFID_HF_CARRIER_DIV 2

// Hysteresis levels of the simulated tag comparator
`define RFID_HI_THRESH_HI 8'd192
`define RFID_HI_THRESH_LO 8'd64

`endif

// ==== rfid_cfg_pkg.sv ====
//--------------------
// Host command and configuration word encodings
// A command is 16 bits with the opcode in [15:12] and the payload in [7:0]
// Bits [11:8] of a command are ignored
//--------------------
package rfid_cfg_pkg;

	// Opcodes carried in the top nibble of a command
	localparam logic [3:0] op_conf    = 4'b0001;
	localparam logic [3:0] op_divisor = 4'b0010;

	//--------------------
	// Major modes held in conf_word[7:5]
	localparam logic [2:0] mode_lo_read     = 3'b000;
	localparam logic [2:0] mode_hi_read_tx  = 3'b010;
	localparam logic [2:0] mode_hi_simulate = 3'b100;
	localparam logic [2:0] mode_off         = 3'b111;

	//--------------------
	// The same byte read by the LF block and by the HF blocks
	typedef union packed {
		// LF view where bit 3 picks the 125 kHz coil setting
		struct packed {
			logic [2:0] major_mode;
			logic       rsvd_hi;
			logic       lo_is_125khz;
			logic [2:0] rsvd_lo;
		} lo;
		// HF view where the low three bits are the per mode option
		// Bit 0 picks shallow depth for transmit
		// For the simulated tag the field is the modulation type
		struct packed {
			logic [2:0] major_mode;
			logic [1:0] rsvd;
			logic [2:0] option;
		} hi;
	} conf_word_u;

endpackage

// ==== rfid_ssp_pkg.sv ====
//--------------------
// Framing of the synchronous serial port towards the host
// The host samples ssp_din on the rising edge of ssp_clk
//--------------------
package rfid_ssp_pkg;

	// Bits in one frame, sent MSB first
	localparam int ssp_frame_bits = 8;

	// Half period of ssp_clk in ncs cycles
	localparam int ssp_clk_half = 2;

endpackage

// ==== spi_config_rx.sv ====
//--------------------
// Host command port, oversampled by ncs
// Each spi_sck phase must last at least 2 ncs cycles
// A command commits within 4 cycles of spi_cs_n rising
//--------------------
`include "rfid_front_defines.svh"

module spi_config_rx (
	input  logic                     ncs,
	input  logic                     rst,
	input  logic                     spi_sck,
	input  logic                     spi_mosi,
	input  logic                     spi_cs_n,
	output rfid_cfg_pkg::conf_word_u conf_word,
	output logic [7:0]               divisor
);
	import rfid_cfg_pkg::*;

	// Stages 0 and 1 synchronize and stage 2 keeps the previous level
	logic [2:0]  sck_q;
	logic [2:0]  cs_n_q;
	logic [1:0]  mosi_q;
	logic [15:0] shift_reg;
	logic        sck_rise;
	logic        cs_rise;

	assign sck_rise = sck_q[1] & ~sck_q[2];
	assign cs_rise  = cs_n_q[1] & ~cs_n_q[2];

	//--------------------
	// Synchronizers
	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			sck_q  <= 3'b000;
			cs_n_q <= 3'b111;
		end
		else
		begin
			sck_q  <= {sck_q[1:0], spi_sck};
			cs_n_q <= {cs_n_q[1:0], spi_cs_n};
		end
	end

	// The data line runs through the same two stages as the clock so they stay aligned
	always_ff @(posedge ncs)
	begin
		mosi_q <= {mosi_q[0], spi_mosi};
		// Shift MSB first while the chip select is held low
		if (sck_rise && !cs_n_q[1])
			shift_reg <= {shift_reg[14:0], mosi_q[1]};
	end

	//--------------------
	// Commit on chip select release
	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			conf_word <= `RFID_CONF_RESET;
			divisor   <= `RFID_DIVISOR_RESET;
		end
		else if (cs_rise)
		begin
			// Any other opcode leaves both registers as they were
			case (shift_reg[15:12])
				op_conf:    conf_word <= shift_reg[7:0];
				op_divisor: divisor   <= shift_reg[7:0];
				default:    ;
			endcase
		end
	end

endmodule

// ==== lo_read.sv ====
//--------------------
// LF reader with the A/D clock at ncs / (2 * (divisor + 1))
// A frame takes 32 cycles, so with divisor below 15 samples are dropped
// Only the newest waiting sample is sent and the host cannot stall the port
//--------------------
`include "rfid_front_defines.svh"

module lo_read (
	input  logic                       ncs,
	input  logic                       rst,
	input  rfid_cfg_pkg::conf_word_u   conf_word,
	input  logic [7:0]                 divisor,
	input  logic [`RFID_ADC_WIDTH-1:0] adc_d,
	output logic                       pwr_lo, pwr_hi,
	output logic                       pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
	output logic                       adc_clk,
	output logic                       ssp_frame, ssp_din, ssp_clk,
	output logic                       dbg
);
	import rfid_ssp_pkg::*;

	logic [7:0]                 div_cnt;
	logic                       div_done;
	logic                       adc_clk_q;
	logic                       adc_fall;
	logic [`RFID_ADC_WIDTH-1:0] hold;
	logic                       hold_valid;
	logic [1:0]                 ssp_cnt;
	logic                       ssp_tick;
	logic                       ssp_clk_q;
	logic                       ssp_fall;
	logic [`RFID_ADC_WIDTH-1:0] shreg;
	logic [2:0]                 bit_cnt;
	logic                       last_bit;
	logic                       busy;
	logic                       load;
	logic                       frame_q;

	//--------------------
	// A/D clock divider
	// The compare is >= so a divisor lowered mid count does not run the counter round
	assign div_done = div_cnt >= divisor;
	assign adc_fall = div_done & adc_clk_q;

	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			div_cnt   <= '0;
			adc_clk_q <= 1'b0;
		end
		else if (div_done)
		begin
			div_cnt   <= '0;
			adc_clk_q <= ~adc_clk_q;
		end
		else
			div_cnt <= div_cnt + 8'd1;
	end

	// One deep holding register, a later sample overwrites an unsent one
	always_ff @(posedge ncs)
	begin
		if (adc_fall)
			hold <= adc_d;
		if (rst)
			hold_valid <= 1'b0;
		else if (adc_fall)
			hold_valid <= 1'b1;
		else if (load)
			hold_valid <= 1'b0;
	end

	//--------------------
	// SSP clock, and the shifter which moves on its falling edge
	assign ssp_tick = ssp_cnt == 2'(ssp_clk_half - 1);
	assign ssp_fall = ssp_tick & ssp_clk_q;
	assign last_bit = bit_cnt == 3'(ssp_frame_bits - 1);
	// A new frame starts when idle or right after the last bit of the previous one
	assign load     = ssp_fall & hold_valid & (~busy | last_bit);

	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			ssp_cnt   <= '0;
			ssp_clk_q <= 1'b0;
		end
		else if (ssp_tick)
		begin
			ssp_cnt   <= '0;
			ssp_clk_q <= ~ssp_clk_q;
		end
		else
			ssp_cnt <= ssp_cnt + 2'd1;
	end

	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			frame_q <= 1'b0;
		end
		else if (ssp_fall)
		begin
			busy    <= load | (busy & ~last_bit);
			bit_cnt <= load ? 3'd0 : bit_cnt + 3'd1;
			// Frame marks the first bit only
			frame_q <= load;
		end
	end

	always_ff @(posedge ncs)
	begin
		if (load)
			shreg <= hold;
		else if (ssp_fall)
			shreg <= {shreg[`RFID_ADC_WIDTH-2:0], 1'b0};
	end

	// Only the LF coil driver toggles, in step with the A/D clock
	assign pwr_lo    = adc_clk_q;
	assign pwr_hi    = 1'b0;
	assign pwr_oe1   = 1'b0;
	assign pwr_oe2   = 1'b0;
	assign pwr_oe3   = 1'b0;
	assign pwr_oe4   = 1'b0;
	assign adc_clk   = adc_clk_q;
	assign ssp_frame = frame_q;
	assign ssp_din   = busy & shreg[`RFID_ADC_WIDTH-1];
	assign ssp_clk   = ssp_clk_q;
	assign dbg       = conf_word.lo.lo_is_125khz | frame_q;

endmodule

// ==== hi_read_tx.sv ====
//--------------------
// HF reader transmit with a carrier of ncs / (2 * RFID_HF_CARRIER_DIV)
// ssp_dout is taken one cycle late and has no framing
//--------------------
`include "rfid_front_defines.svh"

module hi_read_tx (
	input  logic                     ncs,
	input  logic                     rst,
	input  rfid_cfg_pkg::conf_word_u conf_word,
	input  logic                     ssp_dout,
	input  logic                     cross_hi,
	output logic                     pwr_lo, pwr_hi,
	output logic                     pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
	output logic                     adc_clk,
	output logic                     ssp_frame, ssp_din, ssp_clk,
	output logic                     dbg
);
	logic [1:0] car_cnt;
	logic       carrier;
	logic       dout_q;
	logic       cross_q;
	logic       shallow;

	// Option bit 0 picks shallow depth
	assign shallow = conf_word.hi.option[0];

	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			car_cnt <= '0;
			carrier <= 1'b0;
		end
		else if (car_cnt == 2'(`RFID_HF_CARRIER_DIV - 1))
		begin
			car_cnt <= '0;
			carrier <= ~carrier;
		end
		else
			car_cnt <= car_cnt + 2'd1;
	end

	always_ff @(posedge ncs)
	begin
		dout_q  <= ssp_dout;
		cross_q <= cross_hi;
	end

	// Full depth stops the drive, shallow depth keeps it and enables the extra buffer
	assign pwr_hi    = carrier & ~(dout_q & ~shallow);
	assign pwr_oe1   = dout_q & shallow;
	assign pwr_lo    = 1'b0;
	assign pwr_oe2   = 1'b0;
	assign pwr_oe3   = 1'b0;
	assign pwr_oe4   = 1'b0;
	assign adc_clk   = carrier;
	assign ssp_frame = 1'b0;
	assign ssp_din   = cross_q;
	assign ssp_clk   = carrier;
	assign dbg       = dout_q;

endmodule

// ==== hi_simulate.sv ====
//--------------------
// HF simulated tag, the received bit lags adc_d by 2 cycles
// Between the two thresholds the previous bit is kept
//--------------------
`include "rfid_front_defines.svh"

module hi_simulate (
	input  logic                       ncs,
	input  logic                       rst,
	input  rfid_cfg_pkg::conf_word_u   conf_word,
	input  logic [`RFID_ADC_WIDTH-1:0] adc_d,
	input  logic                       ssp_dout,
	output logic                       pwr_lo, pwr_hi,
	output logic                       pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
	output logic                       adc_clk,
	output logic                       ssp_frame, ssp_din, ssp_clk,
	output logic                       dbg
);
	import rfid_ssp_pkg::*;

	// Modulation types in the option field
	localparam logic [2:0] mod_none       = 3'b000;
	localparam logic [2:0] mod_subcarrier = 3'b001;
	localparam logic [2:0] mod_direct     = 3'b010;

	logic [`RFID_ADC_WIDTH-1:0] adc_q;
	logic                       rx_bit;
	logic                       dout_q;
	logic [1:0]                 car_cnt;
	logic                       carrier;
	logic [2:0]                 frame_cnt;
	logic                       mod_on;

	always_ff @(posedge ncs)
	begin
		adc_q  <= adc_d;
		dout_q <= ssp_dout;
	end

	// Hysteresis comparator
	always_ff @(posedge ncs)
	begin
		if (rst)
			rx_bit <= 1'b0;
		else if (adc_q > `RFID_HI_THRESH_HI)
			rx_bit <= 1'b1;
		else if (adc_q < `RFID_HI_THRESH_LO)
			rx_bit <= 1'b0;
	end

	//--------------------
	// Carrier, also counting bit slots for the frame strobe
	always_ff @(posedge ncs)
	begin
		if (rst)
		begin
			car_cnt   <= '0;
			carrier   <= 1'b0;
			frame_cnt <= '0;
		end
		else if (car_cnt == 2'(`RFID_HF_CARRIER_DIV - 1))
		begin
			car_cnt <= '0;
			carrier <= ~carrier;
			// One bit slot ends on each falling carrier edge
			if (carrier)
				frame_cnt <= (frame_cnt == 3'(ssp_frame_bits - 1)) ? 3'd0 : frame_cnt + 3'd1;
		end
		else
			car_cnt <= car_cnt + 2'd1;
	end

	// Load modulation chosen by the option field
	always_comb
	begin
		case (conf_word.hi.option)
			mod_none:       mod_on = 1'b0;
			mod_subcarrier: mod_on = dout_q & carrier;
			mod_direct:     mod_on = dout_q;
			default:        mod_on = 1'b0;
		endcase
	end

	assign pwr_lo    = 1'b0;
	assign pwr_hi    = 1'b0;
	assign pwr_oe1   = mod_on;
	assign pwr_oe2   = 1'b0;
	assign pwr_oe3   = 1'b0;
	assign pwr_oe4   = 1'b0;
	assign adc_clk   = carrier;
	assign ssp_frame = frame_cnt == 3'd0;
	assign ssp_din   = rx_bit;
	assign ssp_clk   = carrier;
	assign dbg       = rx_bit;

endmodule

// ==== front_mux.sv ====
//--------------------
// Pin selector, combinational only
// Mode 111 and every code without a block drive all pins low
//--------------------
module front_mux (
	input  logic [2:0] major_mode,
	input  logic       lr_pwr_lo, lr_pwr_hi,
	input  logic       lr_pwr_oe1, lr_pwr_oe2, lr_pwr_oe3, lr_pwr_oe4,
	input  logic       lr_adc_clk, lr_ssp_frame, lr_ssp_din, lr_ssp_clk, lr_dbg,
	input  logic       ht_pwr_lo, ht_pwr_hi,
	input  logic       ht_pwr_oe1, ht_pwr_oe2, ht_pwr_oe3, ht_pwr_oe4,
	input  logic       ht_adc_clk, ht_ssp_frame, ht_ssp_din, ht_ssp_clk, ht_dbg,
	input  logic       hs_pwr_lo, hs_pwr_hi,
	input  logic       hs_pwr_oe1, hs_pwr_oe2, hs_pwr_oe3, hs_pwr_oe4,
	input  logic       hs_adc_clk, hs_ssp_frame, hs_ssp_din, hs_ssp_clk, hs_dbg,
	output logic       pwr_lo, pwr_hi,
	output logic       pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
	output logic       adc_clk, ssp_frame, ssp_din, ssp_clk, dbg
);
	import rfid_cfg_pkg::*;

	// All eleven pins in the order of the port list
	logic [10:0] pins;

	always_comb
	begin
		case (major_mode)
			mode_lo_read:
				pins = {lr_pwr_lo, lr_pwr_hi, lr_pwr_oe1, lr_pwr_oe2, lr_pwr_oe3, lr_pwr_oe4,
					lr_adc_clk, lr_ssp_frame, lr_ssp_din, lr_ssp_clk, lr_dbg};
			mode_hi_read_tx:
				pins = {ht_pwr_lo, ht_pwr_hi, ht_pwr_oe1, ht_pwr_oe2, ht_pwr_oe3, ht_pwr_oe4,
					ht_adc_clk, ht_ssp_frame, ht_ssp_din, ht_ssp_clk, ht_dbg};
			mode_hi_simulate:
				pins = {hs_pwr_lo, hs_pwr_hi, hs_pwr_oe1, hs_pwr_oe2, hs_pwr_oe3, hs_pwr_oe4,
					hs_adc_clk, hs_ssp_frame, hs_ssp_din, hs_ssp_clk, hs_dbg};
			mode_off:
				pins = '0;
			default:
				pins = '0;
		endcase
	end

	assign {pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
		adc_clk, ssp_frame, ssp_din, ssp_clk, dbg} = pins;

endmodule

// ==== rfid_front.sv ====
//--------------------
// Reader front end top, all logic on ncs
// The active mode block comes from conf_word[7:5]
// adc_noe is held low and nothing is read back over the serial port
//--------------------
`include "rfid_front_defines.svh"

module rfid_front (
	input  logic                       ncs,
	input  logic                       rst,
	input  logic                       spi_sck,
	input  logic                       spi_mosi,
	input  logic                       spi_cs_n,
	input  logic [`RFID_ADC_WIDTH-1:0] adc_d,
	input  logic                       ssp_dout,
	input  logic                       cross_hi,
	output logic                       pwr_lo, pwr_hi,
	output logic                       pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
	output logic                       adc_clk, adc_noe,
	output logic                       ssp_frame, ssp_din, ssp_clk,
	output logic                       dbg
);
	import rfid_cfg_pkg::*;

	conf_word_u conf_word;
	logic [7:0] divisor;

	// Pin bundles of the three mode blocks
	logic lr_pwr_lo, lr_pwr_hi, lr_pwr_oe1, lr_pwr_oe2, lr_pwr_oe3, lr_pwr_oe4;
	logic lr_adc_clk, lr_ssp_frame, lr_ssp_din, lr_ssp_clk, lr_dbg;
	logic ht_pwr_lo, ht_pwr_hi, ht_pwr_oe1, ht_pwr_oe2, ht_pwr_oe3, ht_pwr_oe4;
	logic ht_adc_clk, ht_ssp_frame, ht_ssp_din, ht_ssp_clk, ht_dbg;
	logic hs_pwr_lo, hs_pwr_hi, hs_pwr_oe1, hs_pwr_oe2, hs_pwr_oe3, hs_pwr_oe4;
	logic hs_adc_clk, hs_ssp_frame, hs_ssp_din, hs_ssp_clk, hs_dbg;

	spi_config_rx spi_config_rx_inst (
		.ncs(ncs), .rst(rst),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.conf_word(conf_word), .divisor(divisor)
	);

	//--------------------
	// Mode blocks, always running
	lo_read lo_read_inst (
		.ncs(ncs), .rst(rst), .conf_word(conf_word), .divisor(divisor), .adc_d(adc_d),
		.pwr_lo(lr_pwr_lo), .pwr_hi(lr_pwr_hi), .pwr_oe1(lr_pwr_oe1), .pwr_oe2(lr_pwr_oe2),
		.pwr_oe3(lr_pwr_oe3), .pwr_oe4(lr_pwr_oe4), .adc_clk(lr_adc_clk),
		.ssp_frame(lr_ssp_frame), .ssp_din(lr_ssp_din), .ssp_clk(lr_ssp_clk), .dbg(lr_dbg)
	);

	hi_read_tx hi_read_tx_inst (
		.ncs(ncs), .rst(rst), .conf_word(conf_word), .ssp_dout(ssp_dout), .cross_hi(cross_hi),
		.pwr_lo(ht_pwr_lo), .pwr_hi(ht_pwr_hi), .pwr_oe1(ht_pwr_oe1), .pwr_oe2(ht_pwr_oe2),
		.pwr_oe3(ht_pwr_oe3), .pwr_oe4(ht_pwr_oe4), .adc_clk(ht_adc_clk),
		.ssp_frame(ht_ssp_frame), .ssp_din(ht_ssp_din), .ssp_clk(ht_ssp_clk), .dbg(ht_dbg)
	);

	hi_simulate hi_simulate_inst (
		.ncs(ncs), .rst(rst), .conf_word(conf_word), .adc_d(adc_d), .ssp_dout(ssp_dout),
		.pwr_lo(hs_pwr_lo), .pwr_hi(hs_pwr_hi), .pwr_oe1(hs_pwr_oe1), .pwr_oe2(hs_pwr_oe2),
		.pwr_oe3(hs_pwr_oe3), .pwr_oe4(hs_pwr_oe4), .adc_clk(hs_adc_clk),
		.ssp_frame(hs_ssp_frame), .ssp_din(hs_ssp_din), .ssp_clk(hs_ssp_clk), .dbg(hs_dbg)
	);

	// Both views of the union place the mode in the same bits
	front_mux front_mux_inst (
		.major_mode(conf_word.hi.major_mode),
		.lr_pwr_lo(lr_pwr_lo), .lr_pwr_hi(lr_pwr_hi), .lr_pwr_oe1(lr_pwr_oe1),
		.lr_pwr_oe2(lr_pwr_oe2), .lr_pwr_oe3(lr_pwr_oe3), .lr_pwr_oe4(lr_pwr_oe4),
		.lr_adc_clk(lr_adc_clk), .lr_ssp_frame(lr_ssp_frame), .lr_ssp_din(lr_ssp_din),
		.lr_ssp_clk(lr_ssp_clk), .lr_dbg(lr_dbg),
		.ht_pwr_lo(ht_pwr_lo), .ht_pwr_hi(ht_pwr_hi), .ht_pwr_oe1(ht_pwr_oe1),
		.ht_pwr_oe2(ht_pwr_oe2), .ht_pwr_oe3(ht_pwr_oe3), .ht_pwr_oe4(ht_pwr_oe4),
		.ht_adc_clk(ht_adc_clk), .ht_ssp_frame(ht_ssp_frame), .ht_ssp_din(ht_ssp_din),
		.ht_ssp_clk(ht_ssp_clk), .ht_dbg(ht_dbg),
		.hs_pwr_lo(hs_pwr_lo), .hs_pwr_hi(hs_pwr_hi), .hs_pwr_oe1(hs_pwr_oe1),
		.hs_pwr_oe2(hs_pwr_oe2), .hs_pwr_oe3(hs_pwr_oe3), .hs_pwr_oe4(hs_pwr_oe4),
		.hs_adc_clk(hs_adc_clk), .hs_ssp_frame(hs_ssp_frame), .hs_ssp_din(hs_ssp_din),
		.hs_ssp_clk(hs_ssp_clk), .hs_dbg(hs_dbg),
		.pwr_lo(pwr_lo), .pwr_hi(pwr_hi), .pwr_oe1(pwr_oe1), .pwr_oe2(pwr_oe2),
		.pwr_oe3(pwr_oe3), .pwr_oe4(pwr_oe4), .adc_clk(adc_clk),
		.ssp_frame(ssp_frame), .ssp_din(ssp_din), .ssp_clk(ssp_clk), .dbg(dbg)
	);

	// The A/D outputs stay enabled in every mode
	assign adc_noe = 1'b0;

endmodule

// ==== tb_rfid_front.sv ====
//--------------------
// Table driven testbench for the reader front end, checks run at the falling ncs edge
// Inputs change only on the rising edge, commands are bit-banged at 4 ncs cycles per bit
//--------------------
`include "rfid_front_defines.svh"

module tb_rfid_front;
	timeunit 1ns;
	timeprecision 100ps;

	// Row kinds of the stimulus table
	localparam logic [2:0] k_off    = 3'd0;
	localparam logic [2:0] k_period = 3'd1;
	localparam logic [2:0] k_ssp    = 3'd2;
	localparam logic [2:0] k_tx     = 3'd3;
	localparam logic [2:0] k_cmp    = 3'd4;
	localparam logic [2:0] k_mod    = 3'd5;
	localparam int         n_rows   = 16;

	logic ncs, rst, spi_sck, spi_mosi, spi_cs_n, ssp_dout, cross_hi;
	logic [`RFID_ADC_WIDTH-1:0] adc_d;
	logic pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4;
	logic adc_clk, adc_noe, ssp_frame, ssp_din, ssp_clk, dbg;

	// Row layout is divisor, configuration byte, A/D level or class, ssp_dout, kind
	logic [27:0] table_rows [0:n_rows-1];
	integer      seed = 61860;
	int          errors = 0;
	int          checks = 0;
	// Comparator state as the hysteresis rule predicts it, clear after reset
	logic        exp_rx = 1'b0;

	rfid_front rfid_front_inst (
		.ncs(ncs), .rst(rst), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.adc_d(adc_d), .ssp_dout(ssp_dout), .cross_hi(cross_hi),
		.pwr_lo(pwr_lo), .pwr_hi(pwr_hi), .pwr_oe1(pwr_oe1), .pwr_oe2(pwr_oe2),
		.pwr_oe3(pwr_oe3), .pwr_oe4(pwr_oe4), .adc_clk(adc_clk), .adc_noe(adc_noe),
		.ssp_frame(ssp_frame), .ssp_din(ssp_din), .ssp_clk(ssp_clk), .dbg(dbg)
	);

	// 20 ns clock period
	initial ncs = 1'b0;
	always #10 ncs = ~ncs;

	//--------------------
	// Watchdog sized at 2000 cycles per table row
	initial
	begin
		#(n_rows * 2000 * 20);
		$display("Watchdog expired before the table finished, the run is stuck");
		$display("Simulation failed");
		$finish;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge ncs);
	endtask

	task automatic flag_mismatch(input string msg);
		errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	// Every pin that a mode block can drive, plus the constant enable
	function automatic logic all_pins_low();
		return {pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4, adc_clk, adc_noe,
			ssp_frame, ssp_din, ssp_clk, dbg} === 12'd0;
	endfunction

	// Pins must stay low for longer than one carrier period
	task automatic check_pins_low(input int window, input string msg);
		logic bad;
		bad = 1'b0;
		repeat (window)
		begin
			@(negedge ncs);
			if (!all_pins_low())
				bad = 1'b1;
		end
		checks++;
		if (bad)
			flag_mismatch(msg);
	endtask

	// Class ff gives a level above 192, class 80 one between the thresholds, else below 64
	function automatic logic [7:0] level_for(input logic [7:0] cls, input logic [31:0] rnd);
		if (cls == 8'hff)
			return 8'hc1 | {2'b00, rnd[5:0]};
		else if (cls == 8'h80)
			return 8'h40 + {1'b0, rnd[6:0]};
		return {2'b00, rnd[5:0]};
	endfunction

	//--------------------
	// Bit-bang one command MSB first, each spi_sck phase lasts 2 cycles
	task automatic send_cmd(input logic [15:0] cmd, input int settle);
		int i;
		@(posedge ncs);
		spi_cs_n <= 1'b0;
		for (i = 15; i >= 0; i--)
		begin
			spi_mosi <= cmd[i];
			spi_sck  <= 1'b0;
			wait_cycles(2);
			spi_sck <= 1'b1;
			wait_cycles(2);
		end
		spi_sck <= 1'b0;
		wait_cycles(2);
		spi_cs_n <= 1'b1;
		wait_cycles(settle);
	endtask

	// The first rise may still follow the old divisor, so the gap is taken from the next two
	task automatic check_period(input logic [7:0] d);
		int   rises, cnt, first_at, gap;
		logic prev, pin_bad;
		rises = 0;
		cnt = 0;
		first_at = 0;
		gap = 0;
		pin_bad = 1'b0;
		@(negedge ncs);
		prev = adc_clk;
		while (rises < 3 && cnt < 8 * (d + 1) + 16)
		begin
			@(negedge ncs);
			cnt++;
			if (pwr_lo !== adc_clk || pwr_hi !== 1'b0)
				pin_bad = 1'b1;
			if (!prev && adc_clk)
			begin
				rises++;
				if (rises == 2)
					first_at = cnt;
				gap = cnt - first_at;
			end
			prev = adc_clk;
		end
		checks++;
		if (rises < 3)
		begin
			errors++;
			$display("adc_clk stopped toggling with divisor %0d", d);
		end
		else if (gap != 2 * (d + 1))
			flag_mismatch($sformatf("adc_clk period %0d, expected %0d", gap, 2 * (d + 1)));
		if (pin_bad)
			flag_mismatch("pwr_lo does not follow adc_clk or pwr_hi is not low");
	endtask

	// Old frames drain first, then one frame is read on the ssp_clk rising edges
	task automatic check_ssp(input logic [7:0] expect_val, input logic [7:0] d);
		logic [7:0] got;
		logic       prev_clk;
		int         n, guard;
		got = 8'd0;
		n = 0;
		guard = 0;
		wait_cycles(2 * (d + 1) + 72);
		@(negedge ncs);
		prev_clk = ssp_clk;
		while (n < 8 && guard < 400)
		begin
			@(negedge ncs);
			guard++;
			if (!prev_clk && ssp_clk && (n > 0 || ssp_frame))
			begin
				got = {got[6:0], ssp_din};
				n++;
			end
			prev_clk = ssp_clk;
		end
		checks++;
		if (n < 8)
		begin
			errors++;
			$display("No complete SSP frame seen with divisor %0d", d);
		end
		else if (got !== expect_val)
			flag_mismatch($sformatf("SSP frame %h, expected %h", got, expect_val));
	endtask

	// Watch pwr_hi and pwr_oe1 over a 40 cycle window
	task automatic check_tx(input logic shallow, input logic dout);
		int   toggles, highs;
		logic prev, oe_bad;
		toggles = 0;
		highs = 0;
		oe_bad = 1'b0;
		wait_cycles(2);
		@(negedge ncs);
		prev = pwr_hi;
		repeat (40)
		begin
			@(negedge ncs);
			if (pwr_hi !== prev)
				toggles++;
			if (pwr_hi)
				highs++;
			if (pwr_oe1 !== (shallow & dout))
				oe_bad = 1'b1;
			prev = pwr_hi;
		end
		checks++;
		if (dout && !shallow)
		begin
			if (highs != 0)
				flag_mismatch("pwr_hi driven during full depth modulation");
		end
		else if (toggles == 0)
			flag_mismatch($sformatf("No carrier on pwr_hi, shallow %b ssp_dout %b", shallow, dout));
		if (oe_bad)
			flag_mismatch($sformatf("pwr_oe1 wrong, shallow %b ssp_dout %b", shallow, dout));
	endtask

	//--------------------
	// Stimulus
	initial
	begin
		logic [7:0]  div, conf, lvl;
		logic        dout;
		logic [2:0]  kind;
		logic [31:0] rnd;
		int          r;
		rst = 1'b1;
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_n = 1'b1;
		adc_d = '0;
		ssp_dout = 1'b0;
		cross_hi = 1'b0;
		table_rows[0]  = {8'd20, 8'h00, 8'h5a, 1'b0, k_period};
		table_rows[1]  = {8'd7,  8'h08, 8'h00, 1'b0, k_period};
		table_rows[2]  = {8'd20, 8'h00, 8'ha5, 1'b0, k_ssp};
		table_rows[3]  = {8'd3,  8'h00, 8'h3c, 1'b0, k_ssp};
		table_rows[4]  = {8'd20, 8'h40, 8'h00, 1'b1, k_tx};
		table_rows[5]  = {8'd20, 8'h40, 8'h00, 1'b0, k_tx};
		table_rows[6]  = {8'd20, 8'h41, 8'h00, 1'b1, k_tx};
		table_rows[7]  = {8'd20, 8'h80, 8'hff, 1'b0, k_cmp};
		table_rows[8]  = {8'd20, 8'h80, 8'h80, 1'b0, k_cmp};
		table_rows[9]  = {8'd20, 8'h80, 8'h00, 1'b0, k_cmp};
		table_rows[10] = {8'd20, 8'h80, 8'h80, 1'b0, k_cmp};
		table_rows[11] = {8'd20, 8'h80, 8'hff, 1'b0, k_cmp};
		table_rows[12] = {8'd20, 8'h82, 8'h00, 1'b1, k_mod};
		table_rows[13] = {8'd20, 8'h82, 8'h00, 1'b0, k_mod};
		table_rows[14] = {8'd20, 8'he0, 8'h00, 1'b0, k_off};
		table_rows[15] = {8'd20, 8'ha0, 8'h00, 1'b1, k_off};
		wait_cycles(4);
		rst <= 1'b0;
		wait_cycles(2);
		check_pins_low(8, "Pins not low after reset");
		// Unknown opcode 0011 carrying a mode 010 payload must be ignored
		send_cmd(16'h3040, 8);
		check_pins_low(8, "Opcode 0011 changed the outputs");
		for (r = 0; r < n_rows; r++)
		begin
			{div, conf, lvl, dout, kind} = table_rows[r];
			rnd = $random(seed);
			if (kind == k_cmp)
				lvl = level_for(lvl, rnd);
			send_cmd({4'b0010, 4'h0, div}, 8);
			send_cmd({4'b0001, 4'h0, conf}, (kind == k_off) ? 6 : 8);
			adc_d    <= lvl;
			ssp_dout <= dout;
			if (lvl > `RFID_HI_THRESH_HI)
				exp_rx = 1'b1;
			else if (lvl < `RFID_HI_THRESH_LO)
				exp_rx = 1'b0;
			case (kind)
				k_off:    check_pins_low(8, $sformatf("Pins not low in mode %b", conf[7:5]));
				k_period: check_period(div);
				k_ssp:    check_ssp(lvl, div);
				k_tx:     check_tx(conf[0], dout);
				k_cmp:
				begin
					wait_cycles(4);
					@(negedge ncs);
					checks++;
					if (ssp_din !== exp_rx)
						flag_mismatch($sformatf("adc_d %0d gave ssp_din %b", lvl, ssp_din));
				end
				default:
				begin
					wait_cycles(4);
					@(negedge ncs);
					checks++;
					if (pwr_oe1 !== dout)
						flag_mismatch($sformatf("pwr_oe1 %b with ssp_dout %b", pwr_oe1, dout));
				end
			endcase
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== rfid_front.f ====
+incdir+.
rfid_cfg_pkg.sv
rfid_ssp_pkg.sv
spi_config_rx.sv
lo_read.sv
hi_read_tx.sv
hi_simulate.sv
front_mux.sv
rfid_front.sv
tb_rfid_front.sv
